// ==== mips_core.f ====
mips_pkg.sv
regfile.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

// ==== Makefile ====
# Verilator build and run for the MIPS-subset pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
TRACE     ?= mips_core_trace.txt
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN) $(TRACE)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mips_core_trace.txt ====
# I <instruction hex> : instruction words, in issue order
# R <reg dec> <value hex> : expected write retire, X : expected illegal retire
I 24010005  addiu r1, r0, 5
I 2002FFFD  addi  r2, r0, -3
I 00221821  addu  r3, r1, r2
I 00412023  subu  r4, r2, r1
I 0081282A  slt   r5, r4, r1
I 2826FFFF  slti  r6, r1, -1
I 3047FF0F  andi  r7, r2, 0xff0f
I 34088001  ori   r8, r0, 0x8001
I 3909FFFF  xori  r9, r8, 0xffff
I 3C0A1234  lui   r10, 0x1234
I 01495825  or    r11, r10, r9
I 01676024  and   r12, r11, r7
I AC2B0008  sw    r11, 8(r1)
I 8C6D000A  lw    r13, 10(r3)
I 01A17021  addu  r14, r13, r1
I 24200064  addiu r0, r1, 100
I 10000004  beq   r0, r0, 4
I 000E7821  addu  r15, r0, r14
I 00221818  funct 0x18, not supported
I 00608021  addu  r16, r3, r0
I 8C11000C  lw    r17, 12(r0)
I 00319023  subu  r18, r1, r17
R 1 00000005
R 2 FFFFFFFD
R 3 00000002
R 4 FFFFFFF8
R 5 00000001
R 6 00000000
R 7 0000FF0D
R 8 00008001
R 9 00007FFE
R 10 12340000
R 11 12347FFE
R 12 00007F0C
R 13 12347FFE
R 14 12348003
X
R 15 12348003
X
R 16 00000002
R 17 12347FFE
R 18 EDCB8007

// ==== tb_mips_core.sv ====
// Testbench for mips_core driven from mips_core_trace.txt
// Run from the project root so the trace path resolves
// Instructions are offered with random idle gaps from a fixed seed
// Retire events are compared in order with the expected list
// Stall length on inst_ready is checked for every instruction

`timescale 1ns/1ps

module tb_mips_core
	import mips_pkg::*;
;

	localparam int CLK_PERIOD    = 20;
	localparam int MAX_ENTRIES   = 128;
	localparam int READY_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 50;

	logic                  clk;
	logic                  rst;
	logic                  inst_valid;
	logic [XLEN-1:0]       inst;
	logic                  inst_ready;
	logic                  retire_valid;
	logic [REG_ADDR_W-1:0] retire_reg;
	logic [XLEN-1:0]       retire_data;
	logic                  illegal;

	logic [XLEN-1:0]       prog     [0:MAX_ENTRIES-1];
	logic                  exp_ill  [0:MAX_ENTRIES-1];
	logic [XLEN-1:0]       exp_reg  [0:MAX_ENTRIES-1];
	logic [XLEN-1:0]       exp_data [0:MAX_ENTRIES-1];
	int                    prog_count;
	int                    exp_count;
	int                    exp_idx;
	int                    errors;
	int                    checks;
	integer                seed;
	logic                  started;
	logic                  aborted;
	logic [REG_ADDR_W-1:0] load_dest;

	mips_core #(
		.DMEM_WORDS (64)
	) i_dut (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_ready   (inst_ready),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data),
		.illegal      (illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic check_value(input string what, input logic [XLEN-1:0] actual,
		input logic [XLEN-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic read_trace();
		integer          fd;
		integer          rc;
		string           line;
		logic [7:0]      tag;
		logic [XLEN-1:0] word;
		integer          reg_num;
		fd = $fopen("mips_core_trace.txt", "r");
		if (fd == 0)
		begin
			$display("Error: cannot open the trace file mips_core_trace.txt");
			errors++;
			aborted = 1'b1;
		end
		else
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				// Lines with another first character are notes
				if (rc > 0 && $sscanf(line, " %c", tag) == 1)
				begin
					if (tag == "I" && $sscanf(line, " I %h", word) == 1)
					begin
						prog[prog_count] = word;
						prog_count++;
					end
					else if (tag == "R" && $sscanf(line, " R %d %h", reg_num, word) == 2)
					begin
						exp_ill[exp_count]  = 1'b0;
						exp_reg[exp_count]  = reg_num;
						exp_data[exp_count] = word;
						exp_count++;
					end
					else if (tag == "X")
					begin
						exp_ill[exp_count]  = 1'b1;
						exp_reg[exp_count]  = '0;
						exp_data[exp_count] = '0;
						exp_count++;
					end
				end
			end
			$fclose(fd);
			if (prog_count == 0)
			begin
				$display("Error: the trace file holds no instructions");
				errors++;
				aborted = 1'b1;
			end
		end
	endtask

	// Offer one instruction after a random gap and hold it until taken
	task automatic send_inst(input logic [XLEN-1:0] word);
		integer r;
		int     idle;
		int     wait_cycles;
		int     exp_stall;
		r    = $random(seed);
		idle = (r[3:2] == 2'b00) ? int'(r[1:0]) + 1 : 0;
		// A load still in execute holds back a reader of its destination
		exp_stall = 0;
		if (idle == 0 && load_dest != '0 &&
			(word[25:21] == load_dest || word[20:16] == load_dest))
			exp_stall = 1;
		repeat (idle)
		begin
			@(posedge clk);
			#1;
		end
		inst_valid  = 1'b1;
		inst        = word;
		wait_cycles = 0;
		@(negedge clk);
		while (!inst_ready && !aborted)
		begin
			wait_cycles++;
			if (wait_cycles > READY_TIMEOUT)
			begin
				$display("Timeout: inst_ready stayed low for %0d cycles", READY_TIMEOUT);
				errors++;
				aborted = 1'b1;
			end
			else
				@(negedge clk);
		end
		if (!aborted)
			check_value("inst_ready stall cycles", wait_cycles, exp_stall);
		@(posedge clk);
		#1;
		load_dest  = (word[31:26] == OP_LW) ? word[20:16] : '0;
		started    = 1'b1;
		inst_valid = 1'b0;
	endtask

	task automatic wait_for_retires();
		int cycles;
		cycles = 0;
		while (exp_idx < exp_count && cycles <= DRAIN_TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (exp_idx < exp_count)
		begin
			$display("Timeout: only %0d of %0d retire events arrived", exp_idx, exp_count);
			errors++;
		end
		else
		begin
			// Quiet window to catch extra events
			repeat (4) @(posedge clk);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// ------------------------------
	// Retire monitor
	// ------------------------------
	always @(negedge clk)
	begin
		if (!rst && (retire_valid || illegal))
		begin
			if (!started)
			begin
				$display("Error at %0t ns: retire event before any instruction was taken", $time);
				errors++;
			end
			else if (exp_idx >= exp_count)
			begin
				$display("Error at %0t ns: retire event beyond the expected sequence", $time);
				errors++;
			end
			else
			begin
				check_value($sformatf("event %0d illegal", exp_idx),
					{{(XLEN-1){1'b0}}, illegal}, {{(XLEN-1){1'b0}}, exp_ill[exp_idx]});
				if (exp_ill[exp_idx])
				begin
					check_value($sformatf("event %0d retire_valid", exp_idx),
						{{(XLEN-1){1'b0}}, retire_valid}, '0);
				end
				else
				begin
					check_value($sformatf("event %0d retire_reg", exp_idx),
						{{(XLEN-REG_ADDR_W){1'b0}}, retire_reg}, exp_reg[exp_idx]);
					check_value($sformatf("event %0d retire_data", exp_idx),
						retire_data, exp_data[exp_idx]);
				end
				exp_idx++;
			end
		end
	end

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		seed       = 35;
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		errors     = 0;
		checks     = 0;
		prog_count = 0;
		exp_count  = 0;
		exp_idx    = 0;
		started    = 1'b0;
		aborted    = 1'b0;
		load_dest  = '0;
		read_trace();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < prog_count && !aborted; i++)
			send_inst(prog[i]);
		if (!aborted)
			wait_for_retires();
		finish_run();
	end

endmodule

// ==== mips_core.sv ====
// Top level of the MIPS-subset pipeline
// Instruction input is valid/ready, retire port has no ready
// Retire port doubles as the register file write port
// DMEM_WORDS is a power of two and passed to the memory stage

`timescale 1ns/1ps

module mips_core
	import mips_pkg::*;
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_valid,
	input  logic [XLEN-1:0]       inst,
	output logic                  inst_ready,
	output logic                  retire_valid,
	output logic [REG_ADDR_W-1:0] retire_reg,
	output logic [XLEN-1:0]       retire_data,
	output logic                  illegal
);

	// ------------------------------
	// Register file read port
	// ------------------------------
	logic [REG_ADDR_W-1:0] rf_rs_addr;
	logic [REG_ADDR_W-1:0] rf_rt_addr;
	logic [XLEN-1:0]       rf_rs_data;
	logic [XLEN-1:0]       rf_rt_data;

	// ------------------------------
	// Decode to execute
	// ------------------------------
	logic                  ex_valid;
	alu_op_e               ex_alu_op;
	logic                  ex_use_imm;
	logic [XLEN-1:0]       ex_imm;
	logic [REG_ADDR_W-1:0] ex_rs;
	logic [REG_ADDR_W-1:0] ex_rt;
	logic [XLEN-1:0]       ex_rs_data;
	logic [XLEN-1:0]       ex_rt_data;
	logic [REG_ADDR_W-1:0] ex_dest;
	logic                  ex_reg_write;
	logic                  ex_mem_read;
	logic                  ex_mem_write;
	logic                  ex_illegal;

	// ------------------------------
	// Execute to memory
	// ------------------------------
	logic                  mem_valid;
	logic [XLEN-1:0]       mem_result;
	logic [XLEN-1:0]       mem_store_data;
	logic [REG_ADDR_W-1:0] mem_dest;
	logic                  mem_reg_write;
	logic                  mem_mem_read;
	logic                  mem_mem_write;
	logic                  mem_illegal;

	regfile i_regfile (
		.clk     (clk),
		.rst     (rst),
		.rs_addr (rf_rs_addr),
		.rt_addr (rf_rt_addr),
		.rs_data (rf_rs_data),
		.rt_data (rf_rt_data),
		.wr_en   (retire_valid),
		.wr_addr (retire_reg),
		.wr_data (retire_data)
	);

	decode_stage i_decode (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_ready   (inst_ready),
		.rf_rs_addr   (rf_rs_addr),
		.rf_rt_addr   (rf_rt_addr),
		.rf_rs_data   (rf_rs_data),
		.rf_rt_data   (rf_rt_data),
		.ex_valid     (ex_valid),
		.ex_alu_op    (ex_alu_op),
		.ex_use_imm   (ex_use_imm),
		.ex_imm       (ex_imm),
		.ex_rs        (ex_rs),
		.ex_rt        (ex_rt),
		.ex_rs_data   (ex_rs_data),
		.ex_rt_data   (ex_rt_data),
		.ex_dest      (ex_dest),
		.ex_reg_write (ex_reg_write),
		.ex_mem_read  (ex_mem_read),
		.ex_mem_write (ex_mem_write),
		.ex_illegal   (ex_illegal)
	);

	// Writeback forwarding taps the retire port
	execute_stage i_execute (
		.clk            (clk),
		.rst            (rst),
		.ex_valid       (ex_valid),
		.ex_alu_op      (ex_alu_op),
		.ex_use_imm     (ex_use_imm),
		.ex_imm         (ex_imm),
		.ex_rs          (ex_rs),
		.ex_rt          (ex_rt),
		.ex_rs_data     (ex_rs_data),
		.ex_rt_data     (ex_rt_data),
		.ex_dest        (ex_dest),
		.ex_reg_write   (ex_reg_write),
		.ex_mem_read    (ex_mem_read),
		.ex_mem_write   (ex_mem_write),
		.ex_illegal     (ex_illegal),
		.wb_reg_write   (retire_valid),
		.wb_dest        (retire_reg),
		.wb_data        (retire_data),
		.mem_valid      (mem_valid),
		.mem_result     (mem_result),
		.mem_store_data (mem_store_data),
		.mem_dest       (mem_dest),
		.mem_reg_write  (mem_reg_write),
		.mem_mem_read   (mem_mem_read),
		.mem_mem_write  (mem_mem_write),
		.mem_illegal    (mem_illegal)
	);

	memory_stage #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_memory (
		.clk            (clk),
		.rst            (rst),
		.mem_valid      (mem_valid),
		.mem_result     (mem_result),
		.mem_store_data (mem_store_data),
		.mem_dest       (mem_dest),
		.mem_reg_write  (mem_reg_write),
		.mem_mem_read   (mem_mem_read),
		.mem_mem_write  (mem_mem_write),
		.mem_illegal    (mem_illegal),
		.retire_valid   (retire_valid),
		.retire_reg     (retire_reg),
		.retire_data    (retire_data),
		.illegal        (illegal)
	);

endmodule

// ==== memory_stage.sv ====
// Memory stage: word-addressed data memory and the writeback register
// DMEM_WORDS must be a power of two, at least 2
// Address bits [1:0] are ignored and upper bits wrap modulo the depth
// Loads read combinationally, stores write at the clock edge

`timescale 1ns/1ps

module memory_stage
	import mips_pkg::*;
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mem_valid,
	input  logic [XLEN-1:0]       mem_result,
	input  logic [XLEN-1:0]       mem_store_data,
	input  logic [REG_ADDR_W-1:0] mem_dest,
	input  logic                  mem_reg_write,
	input  logic                  mem_mem_read,
	input  logic                  mem_mem_write,
	input  logic                  mem_illegal,
	output logic                  retire_valid,
	output logic [REG_ADDR_W-1:0] retire_reg,
	output logic [XLEN-1:0]       retire_data,
	output logic                  illegal
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [XLEN-1:0]  dmem [0:DMEM_WORDS-1];
	logic [IDX_W-1:0] word_idx;
	logic [XLEN-1:0]  wb_value;

	assign word_idx = mem_result[IDX_W+1:2];
	assign wb_value = mem_mem_read ? dmem[word_idx] : mem_result;

	// Data memory and writeback control
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
			retire_valid <= 1'b0;
			illegal      <= 1'b0;
		end
		else
		begin
			if (mem_valid && mem_mem_write)
				dmem[word_idx] <= mem_store_data;
			// Writes to r0 never retire
			retire_valid <= mem_valid && mem_reg_write && (mem_dest != '0);
			illegal      <= mem_valid && mem_illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		retire_reg  <= mem_dest;
		retire_data <= wb_value;
	end

endmodule

// ==== execute_stage.sv ====
// Execute stage: operand forwarding, ALU and the execute/memory register
// Forward priority is execute/memory register, then writeback, then decode
// No overflow detection, ADD and SUB wrap
// SLT compares signed

`timescale 1ns/1ps

module execute_stage
	import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ex_valid,
	input  alu_op_e               ex_alu_op,
	input  logic                  ex_use_imm,
	input  logic [XLEN-1:0]       ex_imm,
	input  logic [REG_ADDR_W-1:0] ex_rs,
	input  logic [REG_ADDR_W-1:0] ex_rt,
	input  logic [XLEN-1:0]       ex_rs_data,
	input  logic [XLEN-1:0]       ex_rt_data,
	input  logic [REG_ADDR_W-1:0] ex_dest,
	input  logic                  ex_reg_write,
	input  logic                  ex_mem_read,
	input  logic                  ex_mem_write,
	input  logic                  ex_illegal,
	input  logic                  wb_reg_write,
	input  logic [REG_ADDR_W-1:0] wb_dest,
	input  logic [XLEN-1:0]       wb_data,
	output logic                  mem_valid,
	output logic [XLEN-1:0]       mem_result,
	output logic [XLEN-1:0]       mem_store_data,
	output logic [REG_ADDR_W-1:0] mem_dest,
	output logic                  mem_reg_write,
	output logic                  mem_mem_read,
	output logic                  mem_mem_write,
	output logic                  mem_illegal
);

	logic [XLEN-1:0] rs_val;
	logic [XLEN-1:0] rt_val;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_result;

	// r0 is never forwarded
	function automatic logic [XLEN-1:0] forward(
		input logic [REG_ADDR_W-1:0] src,
		input logic [XLEN-1:0]       dec_val
	);
		if (src == '0)
			return dec_val;
		if (mem_reg_write && (mem_dest == src))
			return mem_result;
		if (wb_reg_write && (wb_dest == src))
			return wb_data;
		return dec_val;
	endfunction

	// ------------------------------
	// Operands
	// ------------------------------
	always_comb
	begin
		rs_val = forward(ex_rs, ex_rs_data);
		rt_val = forward(ex_rt, ex_rt_data);
	end

	assign op_b = ex_use_imm ? ex_imm : rt_val;

	// ------------------------------
	// ALU
	// ------------------------------
	always_comb
	begin
		case (ex_alu_op)
			ALU_ADD: alu_result = rs_val + op_b;
			ALU_SUB: alu_result = rs_val - op_b;
			ALU_AND: alu_result = rs_val & op_b;
			ALU_OR:  alu_result = rs_val | op_b;
			ALU_XOR: alu_result = rs_val ^ op_b;
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
			ALU_LUI: alu_result = {op_b[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

	// ------------------------------
	// Execute/memory register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_valid     <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
			mem_illegal   <= 1'b0;
		end
		else
		begin
			mem_valid     <= ex_valid;
			mem_reg_write <= ex_valid && ex_reg_write;
			mem_mem_read  <= ex_valid && ex_mem_read;
			mem_mem_write <= ex_valid && ex_mem_write;
			mem_illegal   <= ex_valid && ex_illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		mem_result     <= alu_result;
		mem_store_data <= rt_val;
		mem_dest       <= ex_dest;
	end

endmodule

// ==== decode_stage.sv ====
// Decode stage: field split, control decode, immediate and load-use stall
// inst is decoded combinationally and registered at the accepting edge
// A cycle with no accepted instruction loads a bubble into execute
// The load-use check compares rt whatever the format (conservative)

`timescale 1ns/1ps

module decode_stage
	import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_valid,
	input  logic [XLEN-1:0]       inst,
	output logic                  inst_ready,
	output logic [REG_ADDR_W-1:0] rf_rs_addr,
	output logic [REG_ADDR_W-1:0] rf_rt_addr,
	input  logic [XLEN-1:0]       rf_rs_data,
	input  logic [XLEN-1:0]       rf_rt_data,
	output logic                  ex_valid,
	output alu_op_e               ex_alu_op,
	output logic                  ex_use_imm,
	output logic [XLEN-1:0]       ex_imm,
	output logic [REG_ADDR_W-1:0] ex_rs,
	output logic [REG_ADDR_W-1:0] ex_rt,
	output logic [XLEN-1:0]       ex_rs_data,
	output logic [XLEN-1:0]       ex_rt_data,
	output logic [REG_ADDR_W-1:0] ex_dest,
	output logic                  ex_reg_write,
	output logic                  ex_mem_read,
	output logic                  ex_mem_write,
	output logic                  ex_illegal
);

	opcode_e               opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [15:0]           imm16;

	alu_op_e               dec_alu_op;
	logic                  dec_use_imm;
	logic                  dec_zext;
	logic                  dec_rd_dest;
	logic                  dec_reg_write;
	logic                  dec_mem_read;
	logic                  dec_mem_write;
	logic                  dec_illegal;
	logic [XLEN-1:0]       dec_imm;
	logic                  load_use;
	logic                  accept;

	// ------------------------------
	// Field split
	// ------------------------------
	assign opcode = opcode_e'(inst[31:26]);
	assign funct  = funct_e'(inst[5:0]);
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign imm16  = inst[15:0];

	assign rf_rs_addr = rs;
	assign rf_rt_addr = rt;

	// ------------------------------
	// Control decode
	// ------------------------------
	always_comb
	begin
		dec_alu_op    = ALU_ADD;
		dec_use_imm   = 1'b1;
		dec_zext      = 1'b0;
		dec_rd_dest   = 1'b0;
		dec_reg_write = 1'b1;
		dec_mem_read  = 1'b0;
		dec_mem_write = 1'b0;
		dec_illegal   = 1'b0;
		case (opcode)
			OP_R:
			begin
				dec_use_imm = 1'b0;
				dec_rd_dest = 1'b1;
				case (funct)
					FN_ADDU: dec_alu_op = ALU_ADD;
					FN_SUBU: dec_alu_op = ALU_SUB;
					FN_AND:  dec_alu_op = ALU_AND;
					FN_OR:   dec_alu_op = ALU_OR;
					FN_SLT:  dec_alu_op = ALU_SLT;
					default: dec_illegal = 1'b1;
				endcase
			end
			OP_ADDI, OP_ADDIU: dec_alu_op = ALU_ADD;
			OP_SLTI:           dec_alu_op = ALU_SLT;
			OP_ANDI:
			begin
				dec_alu_op = ALU_AND;
				dec_zext   = 1'b1;
			end
			OP_ORI:
			begin
				dec_alu_op = ALU_OR;
				dec_zext   = 1'b1;
			end
			OP_XORI:
			begin
				dec_alu_op = ALU_XOR;
				dec_zext   = 1'b1;
			end
			// ALU moves the zero-extended imm to the upper half
			OP_LUI:
			begin
				dec_alu_op = ALU_LUI;
				dec_zext   = 1'b1;
			end
			OP_LW: dec_mem_read = 1'b1;
			OP_SW:
			begin
				dec_mem_write = 1'b1;
				dec_reg_write = 1'b0;
			end
			default: dec_illegal = 1'b1;
		endcase

		// Illegal codes carry no controls at all
		if (dec_illegal)
		begin
			dec_alu_op    = ALU_ADD;
			dec_reg_write = 1'b0;
			dec_mem_read  = 1'b0;
			dec_mem_write = 1'b0;
		end
	end

	assign dec_imm = dec_zext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	// ------------------------------
	// Load-use stall
	// ------------------------------
	assign load_use   = ex_valid && ex_mem_read && (ex_dest != '0) &&
	                    ((ex_dest == rs) || (ex_dest == rt));
	assign inst_ready = !load_use;
	assign accept     = inst_valid && inst_ready;

	// ------------------------------
	// Decode/execute register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_valid     <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_illegal   <= 1'b0;
		end
		else
		begin
			// Bubble when nothing is accepted
			ex_valid     <= accept;
			ex_reg_write <= accept && dec_reg_write;
			ex_mem_read  <= accept && dec_mem_read;
			ex_mem_write <= accept && dec_mem_write;
			ex_illegal   <= accept && dec_illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_alu_op  <= dec_alu_op;
		ex_use_imm <= dec_use_imm;
		ex_imm     <= dec_imm;
		ex_rs      <= rs;
		ex_rt      <= rt;
		ex_rs_data <= rf_rs_data;
		ex_rt_data <= rf_rt_data;
		ex_dest    <= dec_rd_dest ? rd : rt;
	end

endmodule

// ==== regfile.sv ====
// 32 x XLEN register file, two read ports and one write port
// Register 0 is hardwired to zero, writes to it are ignored
// A write is visible on a read port in the same cycle (bypass)
// Synchronous reset clears every register

`timescale 1ns/1ps

module regfile
	import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	output logic [XLEN-1:0]       rs_data,
	output logic [XLEN-1:0]       rt_data,
	input  logic                  wr_en,
	input  logic [REG_ADDR_W-1:0] wr_addr,
	input  logic [XLEN-1:0]       wr_data
);

	logic [XLEN-1:0] regs [1:31];

	// Zero for r0, then pending write, then stored value
	function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wr_en && (wr_addr == addr))
			return wr_data;
		return regs[addr];
	endfunction

	always_comb
	begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr != '0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// ==== mips_pkg.sv ====
// Shared encodings and widths for the MIPS-subset pipeline
// Opcode and funct values follow the MIPS32 encoding
// Codes outside these enums are treated as illegal by decode
// No branch, jump, multiply or byte access encodings are defined

package mips_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// ------------------------------
	// Primary opcodes, inst[31:26]
	// ------------------------------
	typedef enum logic [5:0]
	{
		OP_R     = 6'b000000,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	// ------------------------------
	// R-type functions, inst[5:0]
	// ------------------------------
	typedef enum logic [5:0]
	{
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010
	} funct_e;

	// ------------------------------
	// ALU operations
	// ------------------------------
	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,
		ALU_LUI = 3'd6
	} alu_op_e;

endpackage
